//--- verilog/riscv_pkg.sv
package riscv_pkg;

    localparam int xlen = 32;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b              // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    branch;
        logic    branch_ne;     // bne when set, beq otherwise
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic [xlen-1:0] branch_target;
        logic            take_branch;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] load_data;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } mem_wb_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            reg_write;  // Low for writes to x0
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } commit_t;

endpackage

//--- verilog/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (flush)
            out_valid <= 1'b0;      // Flush wins over stall
        else if (!stall)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (!stall)
            out_payload <= in_payload;
    end

endmodule

//--- verilog/fetch_unit.sv
module fetch_unit #(
    parameter int imem_words = 256
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         stall,
    input  logic                         redirect,
    input  logic [riscv_pkg::xlen-1:0]   redirect_pc,
    input  logic                         imem_we,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  logic [31:0]                  imem_wdata,
    output riscv_pkg::if_id_t            fetch
);

    localparam int aw = $clog2(imem_words);

    logic [riscv_pkg::xlen-1:0] pc;
    logic [riscv_pkg::xlen-1:0] pc_next;
    logic [31:0]                imem [imem_words];

    always_comb begin
        if (redirect)
            pc_next = redirect_pc;  // Redirect beats a load-use stall
        else if (stall)
            pc_next = pc;
        else
            pc_next = pc + 32'd4;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc <= '0;
        else
            pc <= pc_next;
    end

    // Program load port is only live while the core sits in reset
    always_ff @(posedge clk) begin
        if (!arst_n && imem_we)
            imem[imem_addr] <= imem_wdata;
    end

    always_comb begin
        fetch.pc    = pc;
        fetch.instr = imem[pc[aw+1:2]];
    end

endmodule

//--- verilog/decode_unit.sv
module decode_unit (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  riscv_pkg::if_id_t          in,
    input  logic                       wb_valid,
    input  riscv_pkg::mem_wb_t         wb,
    output riscv_pkg::id_ex_t          out,
    output logic                       commit_valid,
    output riscv_pkg::commit_t         commit,
    output logic [riscv_pkg::xlen-1:0] wb_data
);

    logic [riscv_pkg::xlen-1:0] regs [1:31];
    logic [riscv_pkg::xlen-1:0] rs1_data, rs2_data;
    logic [31:0]                imm_i, imm_s, imm_b, imm_j, imm_u, imm;
    logic [6:0]                 opcode;
    logic [4:0]                 rs1, rs2;
    logic                       wb_we;
    riscv_pkg::ctrl_t           ctrl;

    function automatic riscv_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? riscv_pkg::alu_sub : riscv_pkg::alu_add;
            3'b001:  return riscv_pkg::alu_sll;
            3'b010:  return riscv_pkg::alu_slt;
            3'b100:  return riscv_pkg::alu_xor;
            3'b101:  return riscv_pkg::alu_srl;
            3'b110:  return riscv_pkg::alu_or;
            3'b111:  return riscv_pkg::alu_and;
            default: return riscv_pkg::alu_add;
        endcase
    endfunction

    assign opcode = in.instr[6:0];
    assign rs1    = in.instr[19:15];
    assign rs2    = in.instr[24:20];

    assign imm_i = {{20{in.instr[31]}}, in.instr[31:20]};
    assign imm_s = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
    assign imm_b = {{19{in.instr[31]}}, in.instr[31], in.instr[7], in.instr[30:25],
                    in.instr[11:8], 1'b0};
    assign imm_j = {{11{in.instr[31]}}, in.instr[31], in.instr[19:12], in.instr[20],
                    in.instr[30:21], 1'b0};
    assign imm_u = {in.instr[31:12], 12'b0};

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        case (opcode)
            7'b0110111: begin                       // lui
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = riscv_pkg::alu_pass_b;
                imm              = imm_u;
            end
            7'b0010011: begin                       // op-imm
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_op_of(in.instr[14:12], 1'b0);
            end
            7'b0110011: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_op_of(in.instr[14:12], in.instr[30]);
            end
            7'b0000011: begin                       // lw
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            7'b0100011: begin                       // sw
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_s;
            end
            7'b1100011: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = in.instr[12];
                imm            = imm_b;
            end
            7'b1101111: begin                       // jal
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                imm            = imm_j;
            end
            default: ;
        endcase
        if (!in_valid)
            ctrl = '0;                              // Bubble carries no side effects
    end

    // Writeback select and the register file that never stores x0
    assign wb_data = wb.ctrl.mem_to_reg ? wb.load_data : wb.alu_result;
    assign wb_we   = wb_valid && wb.ctrl.reg_write && (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_we) begin
            regs[wb.rd] <= wb_data;
        end
    end

    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1 != 5'd0)
            rs1_data = (wb_we && wb.rd == rs1) ? wb_data : regs[rs1];   // Write-through
        if (rs2 != 5'd0)
            rs2_data = (wb_we && wb.rd == rs2) ? wb_data : regs[rs2];
    end

    always_comb begin
        out.pc       = in.pc;
        out.rs1_data = rs1_data;
        out.rs2_data = rs2_data;
        out.imm      = imm;
        out.rs1      = rs1;
        out.rs2      = rs2;
        out.rd       = in.instr[11:7];
        out.ctrl     = ctrl;
    end

    assign commit_valid = wb_valid;

    always_comb begin
        commit.pc        = wb.pc;
        commit.reg_write = wb.ctrl.reg_write && (wb.rd != 5'd0);
        commit.rd        = wb.rd;
        commit.data      = wb_data;
    end

endmodule

//--- verilog/execute_unit.sv
module execute_unit (
    input  riscv_pkg::id_ex_t          in,
    input  riscv_pkg::fwd_sel_e        fwd_a,
    input  riscv_pkg::fwd_sel_e        fwd_b,
    input  logic [riscv_pkg::xlen-1:0] mem_fwd_data,
    input  logic [riscv_pkg::xlen-1:0] wb_fwd_data,
    output riscv_pkg::ex_mem_t         out
);

    logic [riscv_pkg::xlen-1:0] op_a, op_b;
    logic [riscv_pkg::xlen-1:0] alu_a, alu_b;
    logic [riscv_pkg::xlen-1:0] result;
    logic                       equal;

    always_comb begin
        case (fwd_a)
            riscv_pkg::fwd_mem: op_a = mem_fwd_data;
            riscv_pkg::fwd_wb:  op_a = wb_fwd_data;
            default:            op_a = in.rs1_data;
        endcase
        case (fwd_b)
            riscv_pkg::fwd_mem: op_b = mem_fwd_data;
            riscv_pkg::fwd_wb:  op_b = wb_fwd_data;
            default:            op_b = in.rs2_data;
        endcase
    end

    // jal computes its link as pc + 4 through the ALU
    assign alu_a = in.ctrl.jump ? in.pc : op_a;
    assign alu_b = in.ctrl.jump ? 32'd4 : (in.ctrl.alu_src_imm ? in.imm : op_b);

    always_comb begin
        case (in.ctrl.alu_op)
            riscv_pkg::alu_add:    result = alu_a + alu_b;
            riscv_pkg::alu_sub:    result = alu_a - alu_b;
            riscv_pkg::alu_and:    result = alu_a & alu_b;
            riscv_pkg::alu_or:     result = alu_a | alu_b;
            riscv_pkg::alu_xor:    result = alu_a ^ alu_b;
            riscv_pkg::alu_slt:    result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            riscv_pkg::alu_sll:    result = alu_a << alu_b[4:0];
            riscv_pkg::alu_srl:    result = alu_a >> alu_b[4:0];
            riscv_pkg::alu_pass_b: result = alu_b;
            default:               result = '0;
        endcase
    end

    assign equal = (op_a == op_b);  // Branch compare uses the forwarded registers

    always_comb begin
        out.pc            = in.pc;
        out.alu_result    = result;
        out.store_data    = op_b;
        out.branch_target = in.pc + in.imm;
        out.take_branch   = in.ctrl.jump ||
                            (in.ctrl.branch && (in.ctrl.branch_ne ? !equal : equal));
        out.rd            = in.rd;
        out.ctrl          = in.ctrl;
    end

endmodule

//--- verilog/hazard_unit.sv
module hazard_unit (
    input  logic [4:0]          id_rs1,
    input  logic [4:0]          id_rs2,
    input  logic                ex_valid,
    input  logic [4:0]          ex_rd,
    input  logic                ex_mem_read,
    input  logic [4:0]          ex_rs1,
    input  logic [4:0]          ex_rs2,
    input  logic                mem_valid,
    input  logic [4:0]          mem_rd,
    input  logic                mem_reg_write,
    input  logic                wb_valid,
    input  logic [4:0]          wb_rd,
    input  logic                wb_reg_write,
    output logic                stall,
    output riscv_pkg::fwd_sel_e fwd_a,
    output riscv_pkg::fwd_sel_e fwd_b
);

    logic mem_ok, wb_ok;

    // Load in EX feeding the instruction in ID
    assign stall = ex_valid && ex_mem_read && (ex_rd != 5'd0) &&
                   (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign mem_ok = mem_valid && mem_reg_write && (mem_rd != 5'd0);
    assign wb_ok  = wb_valid && wb_reg_write && (wb_rd != 5'd0);

    always_comb begin
        fwd_a = riscv_pkg::fwd_reg;
        fwd_b = riscv_pkg::fwd_reg;
        if (mem_ok && mem_rd == ex_rs1)
            fwd_a = riscv_pkg::fwd_mem;     // Youngest result first
        else if (wb_ok && wb_rd == ex_rs1)
            fwd_a = riscv_pkg::fwd_wb;
        if (mem_ok && mem_rd == ex_rs2)
            fwd_b = riscv_pkg::fwd_mem;
        else if (wb_ok && wb_rd == ex_rs2)
            fwd_b = riscv_pkg::fwd_wb;
    end

endmodule

//--- verilog/data_memory.sv
module data_memory #(
    parameter int dmem_words = 256
) (
    input  logic                       clk,
    input  logic                       write,
    input  logic [riscv_pkg::xlen-1:0] addr,
    input  logic [riscv_pkg::xlen-1:0] wdata,
    output logic [riscv_pkg::xlen-1:0] rdata
);

    localparam int aw = $clog2(dmem_words);

    logic [riscv_pkg::xlen-1:0] mem [dmem_words];
    logic [aw-1:0]              index;

    assign index = addr[aw+1:2];        // Word access only

    always_ff @(posedge clk) begin
        if (write)
            mem[index] <= wdata;
    end

    assign rdata = mem[index];

endmodule

//--- verilog/riscv.sv
module riscv #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          imem_we,
    input  logic [$clog2(imem_words)-1:0] imem_addr,
    input  logic [31:0]                   imem_wdata,
    output logic                          commit_valid,
    output riscv_pkg::commit_t            commit
);

    riscv_pkg::if_id_t   fetch, if_id_q;
    riscv_pkg::id_ex_t   decode, id_ex_q;
    riscv_pkg::ex_mem_t  execute, ex_mem_q;
    riscv_pkg::mem_wb_t  mem_stage, mem_wb_q;
    riscv_pkg::fwd_sel_e fwd_a, fwd_b;

    logic                       if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;
    logic                       stall, redirect;
    logic [riscv_pkg::xlen-1:0] wb_data, load_data;

    assign redirect = ex_mem_valid && ex_mem_q.take_branch;

    fetch_unit #(.imem_words(imem_words)) u_fetch (
        .clk, .arst_n, .stall, .redirect,
        .redirect_pc(ex_mem_q.branch_target),
        .imem_we, .imem_addr, .imem_wdata,
        .fetch
    );

    stage_reg #(.payload_t(riscv_pkg::if_id_t)) u_if_id (
        .clk, .arst_n, .stall, .flush(redirect),
        .in_valid(1'b1), .in_payload(fetch),
        .out_valid(if_id_valid), .out_payload(if_id_q)
    );

    decode_unit u_decode (
        .clk, .arst_n,
        .in_valid(if_id_valid), .in(if_id_q),
        .wb_valid(mem_wb_valid), .wb(mem_wb_q),
        .out(decode), .commit_valid, .commit, .wb_data
    );

    hazard_unit u_hazard (
        .id_rs1(if_id_q.instr[19:15]), .id_rs2(if_id_q.instr[24:20]),
        .ex_valid(id_ex_valid), .ex_rd(id_ex_q.rd), .ex_mem_read(id_ex_q.ctrl.mem_read),
        .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2),
        .mem_valid(ex_mem_valid), .mem_rd(ex_mem_q.rd),
        .mem_reg_write(ex_mem_q.ctrl.reg_write),
        .wb_valid(mem_wb_valid), .wb_rd(mem_wb_q.rd),
        .wb_reg_write(mem_wb_q.ctrl.reg_write),
        .stall, .fwd_a, .fwd_b
    );

    // Stall turns the ID/EX capture into a bubble
    stage_reg #(.payload_t(riscv_pkg::id_ex_t)) u_id_ex (
        .clk, .arst_n, .stall(1'b0), .flush(redirect || stall),
        .in_valid(if_id_valid), .in_payload(decode),
        .out_valid(id_ex_valid), .out_payload(id_ex_q)
    );

    execute_unit u_execute (
        .in(id_ex_q), .fwd_a, .fwd_b,
        .mem_fwd_data(ex_mem_q.alu_result), .wb_fwd_data(wb_data),
        .out(execute)
    );

    // The instruction leaving EX is the oldest wrong-path one
    stage_reg #(.payload_t(riscv_pkg::ex_mem_t)) u_ex_mem (
        .clk, .arst_n, .stall(1'b0), .flush(redirect),
        .in_valid(id_ex_valid), .in_payload(execute),
        .out_valid(ex_mem_valid), .out_payload(ex_mem_q)
    );

    data_memory #(.dmem_words(dmem_words)) u_dmem (
        .clk,
        .write(ex_mem_valid && ex_mem_q.ctrl.mem_write),
        .addr(ex_mem_q.alu_result), .wdata(ex_mem_q.store_data),
        .rdata(load_data)
    );

    always_comb begin
        mem_stage.pc         = ex_mem_q.pc;
        mem_stage.alu_result = ex_mem_q.alu_result;
        mem_stage.load_data  = load_data;
        mem_stage.rd         = ex_mem_q.rd;
        mem_stage.ctrl       = ex_mem_q.ctrl;
    end

    stage_reg #(.payload_t(riscv_pkg::mem_wb_t)) u_mem_wb (
        .clk, .arst_n, .stall(1'b0), .flush(1'b0),
        .in_valid(ex_mem_valid), .in_payload(mem_stage),
        .out_valid(mem_wb_valid), .out_payload(mem_wb_q)
    );

endmodule

//--- tests/riscv_tb_asserts.sv
module riscv_tb_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               stall,
    input logic               redirect,
    input riscv_pkg::if_id_t  fetch,
    input logic               ex_mem_valid,
    input riscv_pkg::ex_mem_t ex_mem_q,
    input logic               dmem_write,
    input logic               commit_valid,
    input riscv_pkg::commit_t commit
);

    // Load-use stall freezes the PC unless a redirect overrides it
    pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !redirect |=> fetch.pc == $past(fetch.pc))
        else $error("PC moved during a stall");

    // The three slots behind a taken branch never retire
    flushed_slots: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(redirect, 2) || $past(redirect, 3) || $past(redirect, 4)) |-> !commit_valid)
        else $error("Wrong-path instruction retired after a redirect");

    target_next: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid && $past(redirect, 5) |-> commit.pc == $past(ex_mem_q.branch_target, 5))
        else $error("Commit after a redirect does not start at the branch target");

    // Wrong-path slot after a redirect and load-use bubble reach MEM invalid
    store_slot: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(redirect) || $past(stall, 2)) |-> (!ex_mem_valid && !dmem_write))
        else $error("Flushed or bubble slot reached MEM valid or wrote data memory");

endmodule

bind riscv riscv_tb_asserts u_asserts (
    .clk, .arst_n, .stall, .redirect, .fetch, .ex_mem_valid, .ex_mem_q,
    .dmem_write(u_dmem.write), .commit_valid, .commit
);

//--- tests/riscv_tb.sv
module riscv_tb;

    localparam int imem_words = 256;
    localparam int dmem_words = 256;
    localparam int aw         = $clog2(imem_words);
    localparam int prog_len   = 200;
    localparam int init_len   = 15;                     // x1 to x15 get seeded first
    localparam int max_cycles = 8 * prog_len + 100;
    localparam logic [31:0] nop  = 32'h0000_0013;       // addi x0, x0, 0
    localparam logic [31:0] halt = 32'h0000_006f;       // jal x0, 0

    logic               clk;
    logic               arst_n;
    logic               imem_we;
    logic [aw-1:0]      imem_addr;
    logic [31:0]        imem_wdata;
    logic               commit_valid;
    riscv_pkg::commit_t commit;

    logic [31:0]        prog [prog_len];
    logic [31:0]        ref_regs [32];
    logic [31:0]        ref_mem [64];
    riscv_pkg::commit_t expected_q [$];
    logic [31:0]        halt_pc;
    int                 seed;
    int                 error_count;
    int                 halt_commits;
    int                 cycles;

    riscv #(.imem_words(imem_words), .dmem_words(dmem_words)) i_riscv (
        .clk, .arst_n, .imem_we, .imem_addr, .imem_wdata, .commit_valid, .commit
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(16));
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs1, rs2);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rs1, rs2);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic build_program();
        logic [63:0] written;       // Words whose store runs on every path
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          shadow_end;
        int          kind, k, w;
        written    = '0;
        shadow_end = 0;
        for (int r = 1; r <= init_len; r++) begin
            if (rand_below(2) == 1)
                prog[r-1] = u_type(20'(rand_below(1 << 20)), 5'(r));
            else
                prog[r-1] = i_type(12'(rand_below(4096)), 5'd0, 3'b000, 5'(r), 7'b0010011);
        end
        for (int i = init_len; i < prog_len - 1; i++) begin
            kind = rand_below(16);
            rd   = rand_reg();
            rs1  = rand_reg();
            rs2  = rand_reg();
            imm  = 12'(rand_below(4096));
            if (kind >= 13 && i + 8 > prog_len - 1)
                kind = rand_below(8);           // No room left for a forward jump
            if (kind >= 11 && kind <= 12 && written == '0)
                kind = 5;
            case (kind) inside
                [0:4]: begin
                    w  = rand_below(7);
                    f3 = (w >= 3) ? 3'(w + 1) : 3'(w);      // Skip sltu
                    prog[i] = r_type((f3 == 3'b000 && rand_below(2) == 1) ? 7'h20 : 7'h00,
                                     f3, rd, rs1, rs2);
                end
                [5:7]: begin
                    case (rand_below(5))
                        0:       f3 = 3'b000;
                        1:       f3 = 3'b010;
                        2:       f3 = 3'b100;
                        3:       f3 = 3'b110;
                        default: f3 = 3'b111;
                    endcase
                    prog[i] = i_type(imm, rs1, f3, rd, 7'b0010011);
                end
                8: prog[i] = u_type(20'(rand_below(1 << 20)), rd);
                [9:10]: begin
                    w = rand_below(64);
                    prog[i] = s_type(12'(w * 4), 5'd0, rs2);
                    if (i >= shadow_end)
                        written[w] = 1'b1;
                end
                [11:12]: begin
                    w = rand_below(64);
                    while (!written[w])
                        w = (w + 1) % 64;
                    prog[i] = i_type(12'(w * 4), 5'd0, 3'b010, rd, 7'b0000011);
                end
                default: begin
                    k = 2 + rand_below(7);
                    if (kind == 15)
                        prog[i] = j_type(21'(k * 4), rd);
                    else
                        prog[i] = b_type(13'(k * 4), (kind == 14) ? 3'b001 : 3'b000, rs1,
                                         (rand_below(2) == 1) ? rs1 : rs2);
                    if (i + k > shadow_end)
                        shadow_end = i + k;
                end
            endcase
        end
        prog[prog_len-1] = halt;
    endtask

    // ISA level model of one instruction
    function automatic riscv_pkg::commit_t ref_step(input logic [31:0] pc,
                                                   input logic [31:0] instr,
                                                   output logic [31:0] next_pc);
        riscv_pkg::commit_t c;
        logic [4:0]         rd, rs1, rs2;
        logic [2:0]         f3;
        logic [31:0]        a, b, imm_i, imm_s, imm_b, imm_j, addr, res;
        logic               wr;
        rd      = instr[11:7];
        rs1     = instr[19:15];
        rs2     = instr[24:20];
        f3      = instr[14:12];
        a       = ref_regs[rs1];
        b       = ref_regs[rs2];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        next_pc = pc + 32'd4;
        wr      = 1'b0;
        res     = '0;
        case (instr[6:0])
            7'b0110111: begin
                wr  = 1'b1;
                res = {instr[31:12], 12'b0};
            end
            7'b0010011, 7'b0110011: begin
                wr = 1'b1;
                if (!instr[5])
                    b = imm_i;
                case (f3)
                    3'b000:  res = (instr[5] && instr[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b101:  res = a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0000011: begin
                wr   = 1'b1;
                addr = a + imm_i;
                res  = ref_mem[addr[7:2]];
            end
            7'b0100011: begin
                addr = a + imm_s;
                ref_mem[addr[7:2]] = b;
            end
            7'b1100011: begin
                if ((a == b) != instr[12])
                    next_pc = pc + imm_b;
            end
            7'b1101111: begin
                wr      = 1'b1;
                res     = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            default: ;
        endcase
        if (wr && rd != 5'd0)
            ref_regs[rd] = res;
        c.pc        = pc;
        c.reg_write = wr && (rd != 5'd0);
        c.rd        = rd;
        c.data      = res;
        return c;
    endfunction

    task automatic build_expected();
        logic [31:0] pc;
        logic [31:0] next_pc;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        for (int w = 0; w < 64; w++)
            ref_mem[w] = '0;
        pc = '0;
        for (int n = 0; n < prog_len; n++) begin
            expected_q.push_back(ref_step(pc, prog[int'(pc >> 2)], next_pc));
            if (next_pc == pc)
                break;              // Reached the halt loop
            pc = next_pc;
        end
        halt_pc = pc;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            error_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    always @(negedge clk) begin
        riscv_pkg::commit_t want;
        if (!arst_n) begin
            assert (!commit_valid) else begin
                error_count++;
                $display("Commit valid went high while the core was in reset");
            end
        end else if (commit_valid) begin
            if (expected_q.size() > 0) begin
                want = expected_q.pop_front();
                check_field("commit.pc", commit.pc, want.pc);
                check_field("commit.reg_write", 32'(commit.reg_write), 32'(want.reg_write));
                if (want.reg_write) begin
                    check_field("commit.rd", 32'(commit.rd), 32'(want.rd));
                    check_field("commit.data", commit.data, want.data);
                end
            end else begin
                check_field("commit.pc", commit.pc, halt_pc);
                check_field("commit.reg_write", 32'(commit.reg_write), 32'd0);
                halt_commits++;
            end
        end
    end

    initial begin
        seed         = 32'hb462;
        error_count  = 0;
        halt_commits = 0;
        cycles       = 0;
        arst_n       = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        build_program();
        build_expected();
        for (int a = 0; a < imem_words; a++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = aw'(a);
            imem_wdata = (a < prog_len) ? prog[a] : nop;    // Pad past the program
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        while (!(expected_q.size() == 0 && halt_commits >= 3) && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!(expected_q.size() == 0 && halt_commits >= 3)) begin
            error_count++;
            $display("Timeout after %0d cycles with %0d commits still outstanding",
                     cycles, expected_q.size());
        end
        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- src.f
verilog/riscv_pkg.sv
verilog/stage_reg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/hazard_unit.sv
verilog/data_memory.sv
verilog/riscv.sv
tests/riscv_tb_asserts.sv
tests/riscv_tb.sv

//--- run.sh
#!/bin/sh
# Build the riscv testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module riscv_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vriscv_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1
